//--- src/dram_pkg.sv
/* Shared widths, address window and queue sizes of the AXI-Lite DRAM model
   ReadLatency must be at least 1; the window starts on a word boundary */
package dram_pkg;

    localparam int unsigned AddrWidth = 32;
    localparam int unsigned DataWidth = 64;
    localparam int unsigned RespWidth = 2;

    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [DataWidth-1:0] data_t;
    typedef logic [RespWidth-1:0] resp_t;

    // Address window
    localparam int unsigned WordBytes    = 8;
    localparam int unsigned WordShift    = $clog2(WordBytes);
    localparam addr_t       DramBase     = 32'h8000_0000;
    localparam int unsigned MemWords     = 256;
    localparam int unsigned MemAddrWidth = $clog2(MemWords);
    localparam addr_t       WindowBytes  = addr_t'(MemWords * WordBytes);

    localparam resp_t RespOkay   = 2'b00;
    localparam resp_t RespSlvErr = 2'b10;

    // Write response FIFO
    localparam int unsigned BFifoDepth = 8;
    localparam int unsigned BPtrWidth  = $clog2(BFifoDepth);
    localparam int unsigned BCntWidth  = $clog2(BFifoDepth + 1);

    // Read path of the DRAM model
    localparam int unsigned ReadLatency   = 3;
    localparam int unsigned RspQueueDepth = 4;
    localparam int unsigned QPtrWidth     = $clog2(RspQueueDepth);
    localparam int unsigned QCntWidth     = $clog2(RspQueueDepth + 1);

    typedef enum logic {prio_read, prio_write} arb_state_e;

endpackage

//--- src/lite_req_front.sv
/* AXI-Lite request front: AW and W are taken only together, one grant per cycle
   Out-of-window writes get SLVERR without a memory access */
module lite_req_front import dram_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  addr_t                   aw_addr_i,
    input  logic                    aw_valid_i,
    output logic                    aw_ready_o,
    input  data_t                   w_data_i,
    input  logic                    w_valid_i,
    output logic                    w_ready_o,
    input  addr_t                   ar_addr_i,
    input  logic                    ar_valid_i,
    output logic                    ar_ready_o,
    output logic                    mem_req_valid_o,
    input  logic                    mem_req_ready_i,
    output logic                    mem_we_o,
    output logic [MemAddrWidth-1:0] mem_addr_o,
    output data_t                   mem_wdata_o,
    output logic                    mem_err_o,
    input  logic                    b_full_i,
    output logic                    b_push_o,
    output resp_t                   b_push_resp_o
);

    arb_state_e              arb_q;
    logic                    wr_in_win;
    logic                    rd_in_win;
    logic                    wr_elig;
    logic                    rd_elig;
    logic                    wr_grant;
    logic                    rd_grant;
    logic [MemAddrWidth-1:0] wr_idx;
    logic [MemAddrWidth-1:0] rd_idx;

    // Below DramBase wraps to a large offset and fails too
    function automatic logic in_window(addr_t addr);
        addr_t offset;
        offset = addr - DramBase;
        return offset < WindowBytes;
    endfunction

    function automatic logic [MemAddrWidth-1:0] word_index(addr_t addr);
        addr_t offset;
        offset = addr - DramBase;
        return offset[WordShift +: MemAddrWidth];
    endfunction

    assign wr_in_win = in_window(aw_addr_i);
    assign rd_in_win = in_window(ar_addr_i);
    assign wr_idx    = word_index(aw_addr_i);
    assign rd_idx    = word_index(ar_addr_i);

    // In-window writes also need the memory port
    assign wr_elig = aw_valid_i && w_valid_i && !b_full_i && (!wr_in_win || mem_req_ready_i);
    assign rd_elig = ar_valid_i && mem_req_ready_i;

    always_comb begin
        wr_grant = 1'b0;
        rd_grant = 1'b0;
        if (wr_elig && rd_elig) begin
            if (arb_q == prio_write) begin
                wr_grant = 1'b1;
            end else begin
                rd_grant = 1'b1;
            end
        end else begin
            wr_grant = wr_elig;
            rd_grant = rd_elig;
        end
    end

    // Loser of a contested cycle gets priority next time
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            arb_q <= prio_read;
        end else if (wr_elig && rd_elig) begin
            arb_q <= wr_grant ? prio_read : prio_write;
        end
    end

    assign aw_ready_o = wr_grant;
    assign w_ready_o  = wr_grant;
    assign ar_ready_o = rd_grant;

    assign mem_req_valid_o = rd_grant || (wr_grant && wr_in_win);
    assign mem_we_o        = wr_grant;
    assign mem_addr_o      = wr_grant ? wr_idx : rd_idx;
    assign mem_wdata_o     = w_data_i;
    assign mem_err_o       = rd_grant && !rd_in_win;

    assign b_push_o      = wr_grant;
    assign b_push_resp_o = wr_in_win ? RespOkay : RespSlvErr;

    // Back-to-back contention alternates the winner
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wr_elig && rd_elig && $past(wr_elig && rd_elig) && $past(rst_n_i))
        |-> (wr_grant != $past(wr_grant)));

endmodule

//--- src/b_resp_fifo.sv
/* Registered FIFO of write response codes, drives the B channel
   The writer must not push while full_o is high */
module b_resp_fifo import dram_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  push_i,
    input  resp_t push_resp_i,
    output logic  full_o,
    output logic  b_valid_o,
    output resp_t b_resp_o,
    input  logic  b_ready_i
);

    resp_t                mem_q [BFifoDepth];
    logic [BPtrWidth-1:0] wr_ptr_q;
    logic [BPtrWidth-1:0] rd_ptr_q;
    logic [BCntWidth-1:0] cnt_q;
    logic                 pop;

    assign pop       = b_valid_o && b_ready_i;
    assign full_o    = cnt_q == BCntWidth'(BFifoDepth);
    assign b_valid_o = cnt_q != '0;
    assign b_resp_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == BPtrWidth'(BFifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == BPtrWidth'(BFifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            cnt_q <= cnt_q + BCntWidth'(push_i) - BCntWidth'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_resp_i;
        end
    end

    // Front end must honour full
    assert property (@(posedge clk_i) disable iff (!rst_n_i) full_o |-> !push_i);

endmodule

//--- src/sim_dram_model.sv
/* Memory model with fixed read pipeline and response queue, no DRAM timing
   Memory clears on reset; reads in flight are bounded by RspQueueDepth */
module sim_dram_model import dram_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  logic                    we_i,
    input  logic [MemAddrWidth-1:0] addr_i,
    input  data_t                   wdata_i,
    input  logic                    err_i,
    output logic                    r_valid_o,
    input  logic                    r_ready_i,
    output data_t                   r_data_o,
    output resp_t                   r_resp_o
);

    data_t                  mem_q [MemWords];
    logic [ReadLatency-1:0] pipe_vld_q;
    logic [ReadLatency-1:0] pipe_err_q;
    data_t                  pipe_data_q [ReadLatency];
    data_t                  q_data_q [RspQueueDepth];
    logic [RspQueueDepth-1:0] q_err_q;
    logic [QPtrWidth-1:0]   q_wr_ptr_q;
    logic [QPtrWidth-1:0]   q_rd_ptr_q;
    logic [QCntWidth-1:0]   q_cnt_q;
    logic [QCntWidth-1:0]   pend_q;
    logic                   accept;
    logic                   rd_accept;
    logic                   q_push;
    logic                   q_pop;

    assign accept    = req_valid_i && req_ready_o;
    assign rd_accept = accept && !we_i;
    assign q_push    = pipe_vld_q[ReadLatency-1];
    assign q_pop     = r_valid_o && r_ready_i;

    // Pending covers pipeline plus queue, so the queue never overflows
    assign req_ready_o = pend_q < QCntWidth'(RspQueueDepth);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < MemWords; i++) begin
                mem_q[i] <= '0;
            end
        end else if (accept && we_i) begin
            mem_q[addr_i] <= wdata_i;
        end
    end

    // Read pipeline, data sampled at acceptance
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pipe_vld_q <= '0;
        end else begin
            for (int i = ReadLatency - 1; i > 0; i--) begin
                pipe_vld_q[i] <= pipe_vld_q[i-1];
            end
            pipe_vld_q[0] <= rd_accept;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = ReadLatency - 1; i > 0; i--) begin
            pipe_data_q[i] <= pipe_data_q[i-1];
            pipe_err_q[i]  <= pipe_err_q[i-1];
        end
        pipe_data_q[0] <= err_i ? '0 : mem_q[addr_i];
        pipe_err_q[0]  <= err_i;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            q_wr_ptr_q <= '0;
            q_rd_ptr_q <= '0;
            q_cnt_q    <= '0;
            pend_q     <= '0;
        end else begin
            if (q_push) begin
                q_wr_ptr_q <= (q_wr_ptr_q == QPtrWidth'(RspQueueDepth - 1)) ?
                              '0 : q_wr_ptr_q + 1'b1;
            end
            if (q_pop) begin
                q_rd_ptr_q <= (q_rd_ptr_q == QPtrWidth'(RspQueueDepth - 1)) ?
                              '0 : q_rd_ptr_q + 1'b1;
            end
            q_cnt_q <= q_cnt_q + QCntWidth'(q_push) - QCntWidth'(q_pop);
            pend_q  <= pend_q + QCntWidth'(rd_accept) - QCntWidth'(q_pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (q_push) begin
            q_data_q[q_wr_ptr_q] <= pipe_data_q[ReadLatency-1];
            q_err_q[q_wr_ptr_q]  <= pipe_err_q[ReadLatency-1];
        end
    end

    assign r_valid_o = q_cnt_q != '0;
    assign r_data_o  = q_data_q[q_rd_ptr_q];
    assign r_resp_o  = q_err_q[q_rd_ptr_q] ? RespSlvErr : RespOkay;

    // R payload holds until the handshake
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (r_valid_o && !r_ready_i) |=> (r_valid_o && $stable(r_data_o) && $stable(r_resp_o)));

endmodule

//--- src/lite_dram_sim.sv
/* AXI-Lite slave over a simulated DRAM, one word per beat, no write strobes
   Window is DramBase up to MemWords words; other addresses return SLVERR */
module lite_dram_sim import dram_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  addr_t aw_addr_i,
    input  logic  aw_valid_i,
    output logic  aw_ready_o,
    input  data_t w_data_i,
    input  logic  w_valid_i,
    output logic  w_ready_o,
    output resp_t b_resp_o,
    output logic  b_valid_o,
    input  logic  b_ready_i,
    input  addr_t ar_addr_i,
    input  logic  ar_valid_i,
    output logic  ar_ready_o,
    output data_t r_data_o,
    output resp_t r_resp_o,
    output logic  r_valid_o,
    input  logic  r_ready_i
);

    logic                    mem_req_valid;
    logic                    mem_req_ready;
    logic                    mem_we;
    logic [MemAddrWidth-1:0] mem_addr;
    data_t                   mem_wdata;
    logic                    mem_err;
    logic                    b_push;
    resp_t                   b_push_resp;
    logic                    b_full;

    lite_req_front u_front (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .aw_addr_i       (aw_addr_i),
        .aw_valid_i      (aw_valid_i),
        .aw_ready_o      (aw_ready_o),
        .w_data_i        (w_data_i),
        .w_valid_i       (w_valid_i),
        .w_ready_o       (w_ready_o),
        .ar_addr_i       (ar_addr_i),
        .ar_valid_i      (ar_valid_i),
        .ar_ready_o      (ar_ready_o),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_ready_i (mem_req_ready),
        .mem_we_o        (mem_we),
        .mem_addr_o      (mem_addr),
        .mem_wdata_o     (mem_wdata),
        .mem_err_o       (mem_err),
        .b_full_i        (b_full),
        .b_push_o        (b_push),
        .b_push_resp_o   (b_push_resp)
    );

    b_resp_fifo u_b_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (b_push),
        .push_resp_i (b_push_resp),
        .full_o      (b_full),
        .b_valid_o   (b_valid_o),
        .b_resp_o    (b_resp_o),
        .b_ready_i   (b_ready_i)
    );

    sim_dram_model u_dram (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (mem_req_valid),
        .req_ready_o (mem_req_ready),
        .we_i        (mem_we),
        .addr_i      (mem_addr),
        .wdata_i     (mem_wdata),
        .err_i       (mem_err),
        .r_valid_o   (r_valid_o),
        .r_ready_i   (r_ready_i),
        .r_data_o    (r_data_o),
        .r_resp_o    (r_resp_o)
    );

endmodule

//--- verification/tb_lite_dram_sim.sv
/* Directed testbench for lite_dram_sim with a reference memory and in-order
   checks of B and R; outputs are sampled 1 ns before each rising edge */
module tb_lite_dram_sim import dram_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    // Transactions issued over all tests size the watchdog
    localparam int NumTxn        = 92;
    localparam int TimeoutCycles = NumTxn * 40 + 200;

    logic  clk;
    logic  rst_n;
    addr_t aw_addr;
    logic  aw_valid;
    logic  aw_ready;
    data_t w_data;
    logic  w_valid;
    logic  w_ready;
    resp_t b_resp;
    logic  b_valid;
    logic  b_ready;
    addr_t ar_addr;
    logic  ar_valid;
    logic  ar_ready;
    data_t r_data;
    resp_t r_resp;
    logic  r_valid;
    logic  r_ready;

    data_t  ref_mem [MemWords];
    resp_t  b_exp [$];
    data_t  r_exp_data [$];
    resp_t  r_exp_resp [$];
    int     wr_acc = 0;
    int     rd_acc = 0;
    int     cyc = 0;
    int     ar_cyc = 0;
    int     rise_cyc = 0;
    logic   r_valid_seen = 1'b0;
    integer seed = 32'h95a0_12af;

    lite_dram_sim UUT (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .aw_addr_i  (aw_addr),
        .aw_valid_i (aw_valid),
        .aw_ready_o (aw_ready),
        .w_data_i   (w_data),
        .w_valid_i  (w_valid),
        .w_ready_o  (w_ready),
        .b_resp_o   (b_resp),
        .b_valid_o  (b_valid),
        .b_ready_i  (b_ready),
        .ar_addr_i  (ar_addr),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .r_data_o   (r_data),
        .r_resp_o   (r_resp),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (TimeoutCycles) @(posedge clk);
        $display("Timeout: DUT did not finish %0d transactions in %0d cycles",
                 NumTxn, TimeoutCycles);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check_val(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            $display("FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "protocol error");
    endtask

    // Window of 2 KiB from DramBase with one word per 8 bytes
    function automatic logic addr_in_window(addr_t a);
        return (a >= DramBase) && (a < DramBase + addr_t'(MemWords * WordBytes));
    endfunction

    function automatic int word_of(addr_t a);
        return int'((a - DramBase) / addr_t'(WordBytes));
    endfunction

    function automatic addr_t random_addr();
        logic [31:0] r;
        addr_t       off;
        r = $random(seed);
        off = addr_t'(r[10:0]);
        if (r[31:29] == 3'd0) begin
            return DramBase - 32'd2048 + off;
        end else if (r[31:29] == 3'd1) begin
            return DramBase + 32'd2048 + off;
        end
        return DramBase + off;
    endfunction

    // Reference model updated at each accept in handshake order
    initial begin
        forever begin
            @(negedge clk);
            #4;
            cyc++;
            if ((aw_valid && aw_ready) != (w_valid && w_ready)) begin
                report_error("AW and W handshakes did not happen in the same cycle");
            end
            if (aw_valid && aw_ready) begin
                if (addr_in_window(aw_addr)) begin
                    ref_mem[word_of(aw_addr)] = w_data;
                    b_exp.push_back(RespOkay);
                end else begin
                    b_exp.push_back(RespSlvErr);
                end
                wr_acc++;
            end
            if (ar_valid && ar_ready) begin
                if (addr_in_window(ar_addr)) begin
                    r_exp_data.push_back(ref_mem[word_of(ar_addr)]);
                    r_exp_resp.push_back(RespOkay);
                end else begin
                    r_exp_data.push_back('0);
                    r_exp_resp.push_back(RespSlvErr);
                end
                rd_acc++;
                ar_cyc = cyc;
            end
            if (b_valid && b_ready) begin
                if (b_exp.size() == 0) begin
                    report_error("B response arrived without an accepted write");
                end else begin
                    check_val("b_resp_o", data_t'(b_exp.pop_front()), data_t'(b_resp));
                end
            end
            if (r_valid && r_ready) begin
                if (r_exp_data.size() == 0) begin
                    report_error("R response arrived without an accepted read");
                end else begin
                    check_val("r_data_o", r_exp_data.pop_front(), r_data);
                    check_val("r_resp_o", data_t'(r_exp_resp.pop_front()), data_t'(r_resp));
                end
            end
            if (r_valid && !r_valid_seen) begin
                rise_cyc = cyc;
            end
            r_valid_seen = r_valid;
        end
    end

    task automatic write_req(input addr_t a, input data_t d);
        int n;
        n = wr_acc;
        aw_addr  = a;
        w_data   = d;
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        while (wr_acc == n) @(negedge clk);
        aw_valid = 1'b0;
        w_valid  = 1'b0;
    endtask

    task automatic read_req(input addr_t a);
        int n;
        n = rd_acc;
        ar_addr  = a;
        ar_valid = 1'b1;
        while (rd_acc == n) @(negedge clk);
        ar_valid = 1'b0;
    endtask

    task automatic drain();
        while (b_exp.size() != 0 || r_exp_data.size() != 0) @(negedge clk);
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_val("aw_ready_o", '0, data_t'(aw_ready));
        check_val("w_ready_o", '0, data_t'(w_ready));
        check_val("ar_ready_o", '0, data_t'(ar_ready));
        check_val("b_valid_o", '0, data_t'(b_valid));
        check_val("r_valid_o", '0, data_t'(r_valid));
    endtask

    task automatic test_write_read();
        write_req(DramBase, {$random(seed), $random(seed)});
        write_req(DramBase + 32'h7f8, {$random(seed), $random(seed)});
        write_req(DramBase + 32'h100, {$random(seed), $random(seed)});
        write_req(DramBase + 32'h3a8, {$random(seed), $random(seed)});
        // Low address bits differ from the write
        read_req(DramBase + 32'h3);
        read_req(DramBase + 32'h7ff);
        read_req(DramBase + 32'h104);
        read_req(DramBase + 32'h3a8);
        read_req(DramBase + 32'h200);
        drain();
    endtask

    task automatic test_window();
        write_req(DramBase - 32'd8, 64'hdead_beef_0bad_f00d);
        write_req(DramBase + 32'd2048, 64'h1234_5678_9abc_def0);
        read_req(DramBase - 32'd8);
        read_req(DramBase + 32'd2048);
        // Aliased word indices stay untouched
        read_req(DramBase + 32'h7f8);
        read_req(DramBase);
        drain();
    endtask

    task automatic test_b_backpressure();
        int n0;
        n0 = wr_acc;
        b_ready = 1'b0;
        fork
            begin
                for (int i = 0; i < 10; i++) begin
                    if (i % 2 == 0) begin
                        write_req(DramBase + 32'h400 + addr_t'(i * 8), {32'hb0b0_0000, 32'(i)});
                    end else begin
                        write_req(DramBase + 32'h1000 + addr_t'(i * 8), {32'hbad0_0000, 32'(i)});
                    end
                end
            end
            begin
                repeat (30) @(negedge clk);
                check_val("writes accepted", data_t'(8), data_t'(wr_acc - n0));
                check_val("aw_ready_o", '0, data_t'(aw_ready));
                b_ready = 1'b1;
            end
        join
        drain();
    endtask

    task automatic test_read_latency();
        int n0;
        read_req(DramBase + 32'h100);
        while (rise_cyc <= ar_cyc) @(negedge clk);
        // First seen high in the sample after the edge it rose on
        check_val("r_valid_o latency", data_t'(3), data_t'(rise_cyc - 1 - ar_cyc));
        drain();
        n0 = rd_acc;
        r_ready = 1'b0;
        fork
            begin
                for (int i = 0; i < 6; i++) begin
                    read_req(DramBase + 32'h400 + addr_t'(i * 8));
                end
            end
            begin
                repeat (20) @(negedge clk);
                check_val("reads accepted", data_t'(4), data_t'(rd_acc - n0));
                check_val("ar_ready_o", '0, data_t'(ar_ready));
                r_ready = 1'b1;
            end
        join
        drain();
    endtask

    task automatic test_random_mix();
        logic mix_done;
        mix_done = 1'b0;
        fork
            begin
                logic [31:0] op;
                for (int i = 0; i < 60; i++) begin
                    op = $random(seed);
                    if (op[0]) begin
                        write_req(random_addr(), {$random(seed), $random(seed)});
                    end else begin
                        read_req(random_addr());
                    end
                end
                mix_done = 1'b1;
            end
            begin
                logic [31:0] r;
                while (!mix_done) begin
                    @(negedge clk);
                    r = $random(seed);
                    b_ready = r[1:0] != 2'b00;
                    r_ready = r[3:2] != 2'b00;
                end
                b_ready = 1'b1;
                r_ready = 1'b1;
            end
        join
        drain();
    endtask

    initial begin
        for (int i = 0; i < MemWords; i++) begin
            ref_mem[i] = '0;
        end
        rst_n    = 1'b0;
        aw_addr  = '0;
        aw_valid = 1'b0;
        w_data   = '0;
        w_valid  = 1'b0;
        ar_addr  = '0;
        ar_valid = 1'b0;
        b_ready  = 1'b1;
        r_ready  = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        test_write_read();
        test_window();
        test_b_backpressure();
        test_read_latency();
        test_random_mix();

        @(negedge clk);
        if (b_exp.size() == 0 && r_exp_data.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "responses still outstanding at end of run");
        end
    end

endmodule

//--- lite_dram_sim.f
src/dram_pkg.sv
src/lite_req_front.sv
src/b_resp_fifo.sv
src/sim_dram_model.sv
src/lite_dram_sim.sv
verification/tb_lite_dram_sim.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= lite_dram_sim.f
TB_TOP    ?= tb_lite_dram_sim
RTL_TOP   ?= lite_dram_sim
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= all tests passed

SOURCES := $(wildcard src/*.sv verification/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

# Result is taken from the printed output, not from the exit code
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
